// ==== common/vec_macros.svh ====
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// sizing of the vector slice.
// every width in the package and the modules is derived from these three values.

// vector length in bits, which is a whole number of 32-bit elements.
`define VLEN 64

// number of physical vector registers.
// the register index width follows from this count.
`define NUM_PREGS 16

// number of register file write ports.
// port 0 is the ALU writeback and port 1 is the external load path.
`define NUM_WB 2

`endif // VEC_MACROS_SVH

// ==== common/vec_pkg.sv ====
`include "vec_macros.svh"

package vec_pkg;

    // physical register index, sized from the register count.
    typedef logic [$clog2(`NUM_PREGS)-1:0] preg_t;

    // one full vector register.
    typedef logic [`VLEN-1:0] vbus_t;

    // one mask bit per byte of a vector.
    typedef logic [`VLEN/8-1:0] vmask_t;

    // elementwise operations of the ALU.
    typedef enum logic [2:0] {
        VADD = 3'd0,
        VSUB = 3'd1, // source 1 minus source 2.
        VAND = 3'd2,
        VOR  = 3'd3,
        VXOR = 3'd4,
        VMV  = 3'd5  // copies source 2.
    } vop_e;

    // element width. encoding 3 is not a legal width.
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

    // what a masked-off element receives.
    typedef enum logic {
        UNDISTURBED = 1'b0, // the old destination value.
        AGNOSTIC    = 1'b1  // all ones.
    } mpol_e;

    // one issued instruction.
    typedef struct packed {
        vop_e  op;
        preg_t vs1;
        preg_t vs2;
        preg_t vd;
        preg_t vm_reg;   // register that holds the mask bits.
        logic  use_mask;
    } vinstr_t;

    // one register file write port.
    typedef struct packed {
        logic  we;
        preg_t addr;
        vbus_t data;
    } vwrite_t;

    // active configuration of the slice.
    typedef struct packed {
        sew_e  sew;
        mpol_e policy;
    } vcfg_t;

endpackage

// ==== vregfile/vregfile.sv ====
`timescale 1ns/1ps

`include "vec_macros.svh"

module vregfile (
    input  logic                                clk_i,
    input  vec_pkg::vwrite_t [`NUM_WB-1:0]      wr_i,
    input  vec_pkg::preg_t                      rd_addr1_i,
    input  vec_pkg::preg_t                      rd_addr2_i,
    input  vec_pkg::preg_t                      rd_addr_old_vd_i,
    input  vec_pkg::preg_t                      rd_addr_mask_i,
    input  logic                                use_mask_i,
    output vec_pkg::vbus_t                      rd_data1_o,
    output vec_pkg::vbus_t                      rd_data2_o,
    output vec_pkg::vbus_t                      rd_data_old_vd_o,
    output vec_pkg::vmask_t                     rd_mask_o
);

    import vec_pkg::*;

    vbus_t regs [`NUM_PREGS]; // one entry per physical register.

    vbus_t mask_src;

    // returns the stored value unless an enabled write port targets the same
    // register in this cycle, in which case the write data is forwarded.
    // two ports hitting one address would OR their data together.
    function automatic vbus_t merge_rd(
        preg_t                  addr,
        vbus_t                  stored,
        vwrite_t [`NUM_WB-1:0]  wr
    );
        vbus_t merged;
        logic  hit;

        merged = '0;
        hit    = 1'b0;
        for (int p = 0; p < `NUM_WB; p++) begin
            if (wr[p].we && (wr[p].addr == addr)) begin
                merged |= wr[p].data;
                hit    = 1'b1;
            end
        end
        return hit ? merged : stored;
    endfunction

    // operand read ports.
    assign rd_data1_o       = merge_rd(rd_addr1_i, regs[rd_addr1_i], wr_i);
    assign rd_data2_o       = merge_rd(rd_addr2_i, regs[rd_addr2_i], wr_i);
    assign rd_data_old_vd_o = merge_rd(rd_addr_old_vd_i, regs[rd_addr_old_vd_i], wr_i);

    // the mask port sees the bypass too, so a freshly written mask is usable at once.
    assign mask_src = merge_rd(rd_addr_mask_i, regs[rd_addr_mask_i], wr_i);

    always_comb begin
        if (use_mask_i) begin
            for (int b = 0; b < `VLEN/8; b++) begin
                rd_mask_o[b] = mask_src[8*b]; // the lowest bit of byte b.
            end
        end else begin
            rd_mask_o = '1; // unmasked instructions enable every element.
        end
    end

    // every enabled port writes at the edge.
    // if two ports share an address the higher port wins here, but the
    // result is treated as undefined at the slice level.
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < `NUM_WB; p++) begin
            if (wr_i[p].we) begin
                regs[wr_i[p].addr] <= wr_i[p].data;
            end
        end
    end

endmodule

// ==== rtl/vec_cfg_regs.sv ====
`timescale 1ns/1ps

module vec_cfg_regs (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            cfg_we_i,
    input  vec_pkg::vcfg_t  cfg_i,
    output vec_pkg::vcfg_t  cfg_o,
    output logic            cfg_err_o
);

    import vec_pkg::*;

    vcfg_t cfg_q;
    logic  err_q;
    logic  sew_legal;

    // only the three defined widths are accepted.
    assign sew_legal = cfg_i.sew inside {SEW8, SEW16, SEW32};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q <= '{sew: SEW8, policy: UNDISTURBED};
            err_q <= 1'b0;
        end else if (cfg_we_i) begin
            if (sew_legal) begin
                cfg_q <= cfg_i;
            end else begin
                // the whole write is dropped, policy included.
                err_q <= 1'b1; // sticky until the next reset.
            end
        end
    end

    assign cfg_o     = cfg_q;
    assign cfg_err_o = err_q;

endmodule

// ==== rtl/vec_alu.sv ====
`timescale 1ns/1ps

`include "vec_macros.svh"

module vec_alu (
    input  vec_pkg::vcfg_t  cfg_i,
    input  vec_pkg::vop_e   op_i,
    input  vec_pkg::vbus_t  src1_i,
    input  vec_pkg::vbus_t  src2_i,
    input  vec_pkg::vbus_t  old_vd_i,
    input  vec_pkg::vmask_t mask_i,
    output vec_pkg::vbus_t  result_o
);

    import vec_pkg::*;

    // one element operation on up to 32 bits.
    // narrower elements are zero extended and the caller keeps the low bits,
    // which gives arithmetic modulo the element width.
    function automatic logic [31:0] elem_op(
        vop_e        op,
        logic [31:0] a,
        logic [31:0] b
    );
        case (op)
            VADD:    return a + b;
            VSUB:    return a - b;
            VAND:    return a & b;
            VOR:     return a | b;
            VXOR:    return a ^ b;
            VMV:     return b;
            default: return '0;
        endcase
    endfunction

    // chooses between the computed value and the masked-off value.
    function automatic logic [31:0] apply_mask(
        logic        active,
        logic [31:0] value,
        logic [31:0] old,
        mpol_e       policy
    );
        if (active) begin
            return value;
        end else if (policy == AGNOSTIC) begin
            return '1;
        end else begin
            return old;
        end
    endfunction

    always_comb begin
        logic [31:0] lane;

        result_o = '0;
        lane     = '0;
        case (cfg_i.sew)
            SEW32: begin
                for (int e = 0; e < `VLEN/32; e++) begin
                    lane = elem_op(op_i, src1_i[32*e +: 32], src2_i[32*e +: 32]);
                    lane = apply_mask(mask_i[e], lane, old_vd_i[32*e +: 32], cfg_i.policy);
                    result_o[32*e +: 32] = lane;
                end
            end
            SEW16: begin
                for (int e = 0; e < `VLEN/16; e++) begin
                    lane = elem_op(op_i, {16'h0, src1_i[16*e +: 16]},
                                   {16'h0, src2_i[16*e +: 16]});
                    lane = apply_mask(mask_i[e], lane, {16'h0, old_vd_i[16*e +: 16]},
                                      cfg_i.policy);
                    result_o[16*e +: 16] = lane[15:0]; // the carry out is dropped.
                end
            end
            default: begin
                // SEW8. the config block never holds the illegal encoding.
                for (int e = 0; e < `VLEN/8; e++) begin
                    lane = elem_op(op_i, {24'h0, src1_i[8*e +: 8]},
                                   {24'h0, src2_i[8*e +: 8]});
                    lane = apply_mask(mask_i[e], lane, {24'h0, old_vd_i[8*e +: 8]},
                                      cfg_i.policy);
                    result_o[8*e +: 8] = lane[7:0];
                end
            end
        endcase
    end

endmodule

// ==== rtl/vec_unit_top.sv ====
`timescale 1ns/1ps

`include "vec_macros.svh"

module vec_unit_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             issue_valid_i,
    input  vec_pkg::vinstr_t issue_instr_i,
    input  vec_pkg::vwrite_t ld_wr_i,
    input  logic             cfg_we_i,
    input  vec_pkg::vcfg_t   cfg_i,
    output logic             wb_valid_o,
    output vec_pkg::preg_t   wb_vd_o,
    output vec_pkg::vbus_t   wb_data_o,
    output logic             cfg_err_o
);

    import vec_pkg::*;

    vcfg_t                 cfg_act;
    vbus_t                 src1;
    vbus_t                 src2;
    vbus_t                 old_vd;
    vmask_t                mask;
    vbus_t                 alu_result;
    vwrite_t [`NUM_WB-1:0] rf_wr;

    // writeback stage.
    logic  wb_valid_q;
    preg_t wb_vd_q;
    vbus_t wb_data_q;

    vec_cfg_regs u_cfg (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .cfg_we_i  (cfg_we_i),
        .cfg_i     (cfg_i),
        .cfg_o     (cfg_act),
        .cfg_err_o (cfg_err_o)
    );

    // port 0 retires the ALU result one cycle after issue, port 1 is the load path.
    assign rf_wr[0] = '{we: wb_valid_q, addr: wb_vd_q, data: wb_data_q};
    assign rf_wr[1] = ld_wr_i;

    vregfile u_rf (
        .clk_i            (clk_i),
        .wr_i             (rf_wr),
        .rd_addr1_i       (issue_instr_i.vs1),
        .rd_addr2_i       (issue_instr_i.vs2),
        .rd_addr_old_vd_i (issue_instr_i.vd),
        .rd_addr_mask_i   (issue_instr_i.vm_reg),
        .use_mask_i       (issue_instr_i.use_mask),
        .rd_data1_o       (src1),
        .rd_data2_o       (src2),
        .rd_data_old_vd_o (old_vd),
        .rd_mask_o        (mask)
    );

    vec_alu u_alu (
        .cfg_i    (cfg_act),
        .op_i     (issue_instr_i.op),
        .src1_i   (src1),
        .src2_i   (src2),
        .old_vd_i (old_vd),
        .mask_i   (mask),
        .result_o (alu_result)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= issue_valid_i; // one instruction per cycle, no stalls.
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            wb_vd_q   <= issue_instr_i.vd;
            wb_data_q <= alu_result;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_vd_o    = wb_vd_q;
    assign wb_data_o  = wb_data_q;

endmodule

// ==== testbench/vec_unit_checker.sv ====
`timescale 1ns/1ps

module vec_unit_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic issue_valid_i,
    input logic wb_valid_i,
    input logic cfg_err_i
);

    int unsigned error_count = 0;

    // writeback follows issue by exactly one cycle.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) issue_valid_i |=> wb_valid_i)
        else begin $error("writeback missing one cycle after issue."); error_count++; end
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !issue_valid_i |=> !wb_valid_i)
        else begin $error("writeback without an issue."); error_count++; end

    assert property (@(posedge clk_i) !rst_n_i |-> !wb_valid_i)
        else begin $error("writeback valid during reset."); error_count++; end

    // the configuration error is sticky.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) cfg_err_i |=> cfg_err_i)
        else begin $error("cfg_err_o cleared without a reset."); error_count++; end

endmodule

bind vec_unit_top vec_unit_checker u_checker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .wb_valid_i    (wb_valid_o),
    .cfg_err_i     (cfg_err_o)
);

// ==== testbench/vec_unit_tb.sv ====
`timescale 1ns/1ps

`include "vec_macros.svh"

module vec_unit_tb;

    import vec_pkg::*;

    // rough cycle budget of all tests. the timeout leaves twice that.
    localparam int TEST_CYCLES    = 9 + 32 + 3 * 20 + 6 * 6 + 12 + 8;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic    clk_i;
    logic    rst_n_i;
    logic    issue_valid_i;
    vinstr_t issue_instr_i;
    vwrite_t ld_wr_i;
    logic    cfg_we_i;
    vcfg_t   cfg_i;
    logic    wb_valid_o;
    preg_t   wb_vd_o;
    vbus_t   wb_data_o;
    logic    cfg_err_o;

    vbus_t   model_regs [`NUM_PREGS]; // expected register contents.
    vcfg_t   model_cfg;
    logic    model_err;
    preg_t   exp_vd_q [$];
    vbus_t   exp_data_q [$];
    int      cycle_count = 0;

    vec_unit_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        abort_run($sformatf("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run("timeout: the tests ran past their cycle budget");
        end
    end

    function automatic vbus_t rand_vec();
        return vbus_t'({$urandom(), $urandom()});
    endfunction

    // bit k of the mask is the lowest bit of byte k of the mask register.
    function automatic vmask_t mask_of(preg_t vm, logic use_mask);
        vmask_t m;
        m = '1;
        if (use_mask) begin
            for (int k = 0; k < `VLEN / 8; k++) begin
                m[k] = model_regs[vm][8 * k];
            end
        end
        return m;
    endfunction

    // per-element result, modulo the element width, no carry between elements.
    function automatic vbus_t expect_result(vop_e op, vcfg_t cfg, vbus_t a, vbus_t b,
                                            vbus_t old, vmask_t m);
        int          w;
        logic [63:0] lim;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] r;
        vbus_t       res;
        w   = 8 << cfg.sew;
        lim = (64'd1 << w) - 64'd1;
        res = '0;
        for (int e = 0; e < `VLEN / w; e++) begin
            ea = (a >> (e * w)) & lim;
            eb = (b >> (e * w)) & lim;
            case (op)
                VADD:    r = ea + eb;
                VSUB:    r = ea - eb;
                VAND:    r = ea & eb;
                VOR:     r = ea | eb;
                VXOR:    r = ea ^ eb;
                VMV:     r = eb;
                default: r = '0;
            endcase
            if (!m[e]) begin
                r = (cfg.policy == AGNOSTIC) ? lim : (old >> (e * w));
            end
            res |= vbus_t'(r & lim) << (e * w);
        end
        return res;
    endfunction

    // moves to the next falling edge and checks what the last edge produced.
    task automatic next_cycle();
        preg_t vd;
        vbus_t data;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        ld_wr_i.we    = 1'b0;
        cfg_we_i      = 1'b0;
        assert (dut_i.u_checker.error_count == 0)
            else abort_run("a timing assertion in the bound checker failed");
        if (exp_vd_q.size() > 0) begin
            vd   = exp_vd_q.pop_front();
            data = exp_data_q.pop_front();
            assert (wb_valid_o) else report_mismatch("wb_valid_o", wb_valid_o, 1);
            assert (wb_vd_o == vd) else report_mismatch("wb_vd_o", wb_vd_o, vd);
            assert (wb_data_o == data) else report_mismatch("wb_data_o", wb_data_o, data);
        end else begin
            assert (!wb_valid_o) else report_mismatch("wb_valid_o", wb_valid_o, 0);
        end
        assert (cfg_err_o == model_err) else report_mismatch("cfg_err_o", cfg_err_o, model_err);
    endtask

    task automatic send_instr(vop_e op, preg_t vs1, preg_t vs2, preg_t vd,
                              preg_t vm, logic use_mask);
        vbus_t exp;
        exp = expect_result(op, model_cfg, model_regs[vs1], model_regs[vs2],
                            model_regs[vd], mask_of(vm, use_mask));
        model_regs[vd] = exp;
        exp_vd_q.push_back(vd);
        exp_data_q.push_back(exp);
        issue_instr_i.op       = op;
        issue_instr_i.vs1      = vs1;
        issue_instr_i.vs2      = vs2;
        issue_instr_i.vd       = vd;
        issue_instr_i.vm_reg   = vm;
        issue_instr_i.use_mask = use_mask;
        issue_valid_i          = 1'b1;
    endtask

    task automatic load_reg(preg_t addr, vbus_t data);
        ld_wr_i.we      = 1'b1;
        ld_wr_i.addr    = addr;
        ld_wr_i.data    = data;
        model_regs[addr] = data;
    endtask

    task automatic set_cfg(logic [1:0] sew_bits, mpol_e pol);
        cfg_we_i      = 1'b1;
        cfg_i.sew     = sew_e'(sew_bits);
        cfg_i.policy  = pol;
        if (sew_bits != 2'd3) begin
            model_cfg.sew    = sew_e'(sew_bits);
            model_cfg.policy = pol;
        end else begin
            model_err = 1'b1; // the write is dropped and the error sticks.
        end
        next_cycle();
    endtask

    task automatic load_and_move_all();
        for (int r = 0; r < `NUM_PREGS; r++) begin
            load_reg(preg_t'(r), rand_vec());
            next_cycle();
        end
        for (int r = 0; r < `NUM_PREGS; r++) begin
            // source 1 names another register, so only source 2 may come back.
            send_instr(VMV, preg_t'(r + 1), preg_t'(r), preg_t'(r), '0, 1'b0);
            next_cycle();
        end
    endtask

    task automatic arith_per_width();
        vop_e ops [5] = '{VADD, VSUB, VAND, VOR, VXOR};
        for (int s = 0; s < 3; s++) begin
            set_cfg(2'(s), UNDISTURBED);
            load_reg(14, '1);
            next_cycle();
            load_reg(15, {(`VLEN / 8){8'h01}}); // carries hit every element boundary.
            next_cycle();
            foreach (ops[i]) begin
                for (int t = 0; t < 3; t++) begin
                    send_instr(ops[i], preg_t'($urandom_range(15)),
                               preg_t'($urandom_range(15)),
                               preg_t'($urandom_range(11)), '0, 1'b0);
                    next_cycle();
                end
            end
            send_instr(VADD, 14, 15, 13, '0, 1'b0);
            next_cycle();
            send_instr(VSUB, 15, 14, 12, '0, 1'b0);
            next_cycle();
        end
    endtask

    task automatic mask_policies();
        vbus_t mask_val;
        for (int s = 0; s < 3; s++) begin
            for (int p = 0; p < 2; p++) begin
                set_cfg(2'(s), mpol_e'(p));
                mask_val    = rand_vec();
                mask_val[0] = 1'b1; // at least one active and one inactive element.
                mask_val[8] = 1'b0;
                load_reg(5, mask_val);
                next_cycle();
                load_reg(1, rand_vec());
                next_cycle();
                load_reg(2, rand_vec());
                next_cycle();
                load_reg(3, rand_vec());
                next_cycle();
                send_instr(VADD, 1, 2, 3, 5, 1'b1);
                next_cycle();
            end
        end
    endtask

    task automatic bypass_forwarding();
        set_cfg(2'd2, UNDISTURBED);
        load_reg(1, rand_vec());
        next_cycle();
        load_reg(2, rand_vec());
        next_cycle();
        send_instr(VADD, 1, 2, 4, '0, 1'b0);
        next_cycle();
        send_instr(VXOR, 4, 1, 6, '0, 1'b0); // r4 only reaches the file at this edge.
        next_cycle();
        send_instr(VSUB, 6, 4, 7, '0, 1'b0);
        next_cycle();
        next_cycle();
        load_reg(9, rand_vec());
        send_instr(VMV, 9, 9, 10, '0, 1'b0);
        next_cycle();
        load_reg(11, rand_vec()); // mask register written in the same cycle.
        send_instr(VOR, 1, 2, 12, 11, 1'b1);
        next_cycle();
        next_cycle();
    endtask

    task automatic illegal_cfg_write();
        set_cfg(2'd1, UNDISTURBED);
        set_cfg(2'd3, AGNOSTIC);
        load_reg(14, '1);
        next_cycle();
        load_reg(15, {(`VLEN / 8){8'h01}});
        next_cycle();
        send_instr(VADD, 14, 15, 13, '0, 1'b0); // 16-bit lanes give 0x0100 each.
        next_cycle();
        set_cfg(2'd0, UNDISTURBED);
        next_cycle();
    endtask

    initial begin
        void'($urandom(32'hef81_3960));
        rst_n_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_instr_i = '0;
        ld_wr_i       = '0;
        cfg_we_i      = 1'b0;
        cfg_i         = '0;
        model_cfg     = '{sew: SEW8, policy: UNDISTURBED};
        model_err     = 1'b0;
        #1 rst_n_i = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        load_and_move_all();
        arith_per_width();
        mask_policies();
        bypass_forwarding();
        illegal_cfg_write();

        if (dut_i.u_checker.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("a timing assertion in the bound checker failed");
        end
    end

endmodule

// ==== project.f ====
+incdir+common
common/vec_pkg.sv
vregfile/vregfile.sv
rtl/vec_cfg_regs.sv
rtl/vec_alu.sv
rtl/vec_unit_top.sv
testbench/vec_unit_checker.sv
testbench/vec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: vec_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/vec_pkg.sv
      - vregfile/vregfile.sv
      - rtl/vec_cfg_regs.sv
      - rtl/vec_alu.sv
      - rtl/vec_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/vec_unit_checker.sv
      - testbench/vec_unit_tb.sv
